// ==== filelist.f ====
+incdir+include
source/rv_exec_pkg.sv
source/rv_decoder.sv
source/rv_regfile.sv
source/rv_execute.sv
source/rv_exec_top.sv
test/tb_rv_exec.sv

// ==== include/rv_exec_macros.svh ====
// Datapath width macros assume RV64 with 32-bit instructions and 32 integer registers

`ifndef RV_EXEC_MACROS_SVH
`define RV_EXEC_MACROS_SVH

// integer datapath width
`define RV_XLEN 64

// instruction word width
`define RV_INST_BITS 32

// register index width and register count
`define RV_NREG_BITS 5
`define RV_NREG 32

// low half used by the word forms
`define RV_WORD_BITS 32

// shift amount widths for full and word shifts
`define RV_SHAMT_BITS 6
`define RV_SHAMTW_BITS 5

`endif

// ==== run_sim.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert --top-module tb_rv_exec -f filelist.f

status=0
./obj_dir/Vtb_rv_exec > sim.log 2>&1 || status=$?
cat sim.log

if grep -q "Regression failed" sim.log || [ "$status" -ne 0 ]; then
  exit 1
fi
exit 0

// ==== source/rv_decoder.sv ====
// Decoder for an RV64I subset plus rem and remw where loads and stores decode as illegal
`timescale 1ns/1ns
`include "rv_exec_macros.svh"

module rv_decoder (
  input  logic [`RV_INST_BITS-1:0] i_inst,
  output logic [`RV_NREG_BITS-1:0] o_rs1,
  output logic [`RV_NREG_BITS-1:0] o_rs2,
  output logic [`RV_NREG_BITS-1:0] o_rd,
  output logic [`RV_XLEN-1:0]      o_imm,
  output rv_exec_pkg::alu_op_e     o_alu_op,
  output rv_exec_pkg::src_b_e      o_src_b,
  output logic                     o_src_a_pc,
  output logic                     o_word_cut,
  output rv_exec_pkg::branch_e     o_branch,
  output logic                     o_we,
  output logic                     o_halt,
  output logic                     o_illegal
);
  import rv_exec_pkg::*;

  localparam logic [6:0] opc_op        = 7'b0110011;
  localparam logic [6:0] opc_op_imm    = 7'b0010011;
  localparam logic [6:0] opc_op_32     = 7'b0111011;
  localparam logic [6:0] opc_op_imm_32 = 7'b0011011;
  localparam logic [6:0] opc_lui       = 7'b0110111;
  localparam logic [6:0] opc_auipc     = 7'b0010111;
  localparam logic [6:0] opc_jal       = 7'b1101111;
  localparam logic [6:0] opc_jalr      = 7'b1100111;
  localparam logic [6:0] opc_branch    = 7'b1100011;
  localparam logic [6:0] opc_system    = 7'b1110011;
  localparam logic [`RV_INST_BITS-1:0] inst_ebreak = 32'h0010_0073;

  logic [6:0] opcode;
  logic [2:0] funct3;
  logic [6:0] funct7;
  logic [`RV_XLEN-1:0] imm_i, imm_u, imm_j, imm_b;

  assign opcode = i_inst[6:0];
  assign funct3 = i_inst[14:12];
  assign funct7 = i_inst[31:25];
  assign o_rd   = i_inst[11:7];
  assign o_rs1  = i_inst[19:15];
  assign o_rs2  = i_inst[24:20];

  assign imm_i = {{(`RV_XLEN-12){i_inst[31]}}, i_inst[31:20]};
  assign imm_u = {{(`RV_XLEN-32){i_inst[31]}}, i_inst[31:12], 12'b0};
  assign imm_j = {{(`RV_XLEN-21){i_inst[31]}}, i_inst[31], i_inst[19:12], i_inst[20],
                  i_inst[30:21], 1'b0};
  assign imm_b = {{(`RV_XLEN-13){i_inst[31]}}, i_inst[31], i_inst[7], i_inst[30:25],
                  i_inst[11:8], 1'b0};

  always_comb begin
    o_imm      = imm_i;
    o_alu_op   = alu_add;
    o_src_b    = srcb_rs2;
    o_src_a_pc = 1'b0;
    o_word_cut = 1'b0;
    o_branch   = br_none;
    o_we       = 1'b0;
    o_halt     = 1'b0;
    o_illegal  = 1'b0;
    case (opcode)
      opc_op, opc_op_32: begin
        o_we       = 1'b1;
        o_word_cut = (opcode == opc_op_32);
        case ({funct7, funct3})
          {7'b0000000, 3'b000}: o_alu_op = alu_add;
          {7'b0100000, 3'b000}: o_alu_op = alu_sub;
          {7'b0000000, 3'b001}: o_alu_op = alu_sll;
          {7'b0000000, 3'b011}: o_alu_op = (opcode == opc_op) ? alu_sltu : alu_add;
          {7'b0000000, 3'b110}: o_alu_op = (opcode == opc_op) ? alu_or : alu_add;
          {7'b0000001, 3'b110}: o_alu_op = alu_rem;
          default:              o_illegal = 1'b1;
        endcase
        // sltu and or have no word form
        if (opcode == opc_op_32 && funct7 == 7'b0 && (funct3 == 3'b011 || funct3 == 3'b110))
          o_illegal = 1'b1;
      end
      opc_op_imm, opc_op_imm_32: begin
        o_we       = 1'b1;
        o_src_b    = srcb_imm;
        o_word_cut = (opcode == opc_op_imm_32);
        case (funct3)
          3'b000: o_alu_op = alu_add;
          3'b001: begin
            o_alu_op  = alu_sll;
            // rv64 slli has a 6-bit shamt, slliw a 5-bit one
            o_illegal = o_word_cut ? (funct7 != 7'b0) : (funct7[6:1] != 6'b0);
          end
          3'b011: begin
            o_alu_op  = alu_sltu;
            o_illegal = o_word_cut;
          end
          3'b110: begin
            o_alu_op  = alu_or;
            o_illegal = o_word_cut;
          end
          default: o_illegal = 1'b1;
        endcase
      end
      opc_lui: begin
        o_imm    = imm_u;
        o_alu_op = alu_copy_imm;
        o_we     = 1'b1;
      end
      opc_auipc: begin
        o_imm      = imm_u;
        o_src_a_pc = 1'b1;
        o_src_b    = srcb_imm;
        o_we       = 1'b1;
      end
      opc_jal, opc_jalr: begin
        // link value is pc plus four
        o_imm      = (opcode == opc_jal) ? imm_j : imm_i;
        o_src_a_pc = 1'b1;
        o_src_b    = srcb_four;
        o_branch   = (opcode == opc_jal) ? br_jal : br_jalr;
        o_we       = 1'b1;
        o_illegal  = (opcode == opc_jalr) && (funct3 != 3'b000);
      end
      opc_branch: begin
        o_imm    = imm_b;
        o_alu_op = alu_sub;
        case (funct3)
          3'b000:  o_branch = br_beq;
          3'b001:  o_branch = br_bne;
          3'b100:  o_branch = br_blt;
          3'b101:  o_branch = br_bge;
          default: o_illegal = 1'b1;
        endcase
      end
      opc_system: begin
        o_halt    = (i_inst == inst_ebreak);
        o_illegal = (i_inst != inst_ebreak);
      end
      default: o_illegal = 1'b1;
    endcase
    if (o_illegal) begin
      o_we     = 1'b0;
      o_branch = br_none;
    end
  end

endmodule

// ==== source/rv_exec_pkg.sv ====
// Control encodings follow the reference ALU and branch codes and must match the decoder

package rv_exec_pkg;

  // alu operation, codes kept from the reference alu control
  typedef enum logic [3:0] {
    alu_add      = 4'b0000,
    alu_sll      = 4'b0001,
    alu_copy_imm = 4'b0011,
    alu_or       = 4'b0110,
    alu_sub      = 4'b1000,
    alu_sltu     = 4'b1010,
    alu_rem      = 4'b1101
  } alu_op_e;

  // next pc rule
  typedef enum logic [2:0] {
    br_none = 3'b000,
    br_jal  = 3'b001,
    br_jalr = 3'b010,
    br_beq  = 3'b100,
    br_bne  = 3'b101,
    br_blt  = 3'b110,
    br_bge  = 3'b111
  } branch_e;

  // operand b source
  typedef enum logic [1:0] {
    srcb_rs2  = 2'b00,
    srcb_imm  = 2'b01,
    srcb_four = 2'b10
  } src_b_e;

  // 3'b011 is not a valid branch code
  // and 2'b11 is not a valid operand b source

endpackage

// ==== source/rv_exec_top.sv ====
// Top level keeps at most one instruction in flight and has no load or store path
`timescale 1ns/1ns
`include "rv_exec_macros.svh"

module rv_exec_top (
  input  logic                     i_clk,
  input  logic                     i_reset,
  input  logic                     i_inst_valid,
  input  logic [`RV_INST_BITS-1:0] i_inst,
  input  logic [`RV_XLEN-1:0]      i_pc,
  output logic                     o_inst_ready,
  output logic                     o_commit_valid,
  output logic [`RV_XLEN-1:0]      o_commit_pc,
  output logic [`RV_XLEN-1:0]      o_commit_next_pc,
  output logic [`RV_NREG_BITS-1:0] o_commit_rd,
  output logic [`RV_XLEN-1:0]      o_commit_wdata,
  output logic                     o_commit_we,
  output logic                     o_commit_halt,
  output logic                     o_commit_illegal,
  input  logic                     i_commit_ready
);
  import rv_exec_pkg::*;

  logic [`RV_NREG_BITS-1:0] rs1, rs2, rd, wb_addr;
  logic [`RV_XLEN-1:0]      imm, rs1_data, rs2_data, wb_data;
  alu_op_e                  alu_op;
  src_b_e                   src_b;
  branch_e                  branch;
  logic                     src_a_pc, word_cut, we, halt, illegal, wb_we;

  rv_decoder u_decoder (
    .i_inst(i_inst), .o_rs1(rs1), .o_rs2(rs2), .o_rd(rd), .o_imm(imm),
    .o_alu_op(alu_op), .o_src_b(src_b), .o_src_a_pc(src_a_pc), .o_word_cut(word_cut),
    .o_branch(branch), .o_we(we), .o_halt(halt), .o_illegal(illegal)
  );

  rv_regfile u_regfile (
    .i_clk(i_clk), .i_reset(i_reset), .i_raddr1(rs1), .i_raddr2(rs2),
    .i_waddr(wb_addr), .i_wdata(wb_data), .i_we(wb_we),
    .o_rdata1(rs1_data), .o_rdata2(rs2_data)
  );

  rv_execute u_execute (
    .i_clk(i_clk), .i_reset(i_reset), .i_inst_valid(i_inst_valid), .i_pc(i_pc),
    .i_rs1_data(rs1_data), .i_rs2_data(rs2_data), .i_imm(imm), .i_alu_op(alu_op),
    .i_src_b(src_b), .i_src_a_pc(src_a_pc), .i_word_cut(word_cut), .i_branch(branch),
    .i_rd(rd), .i_we(we), .i_halt(halt), .i_illegal(illegal),
    .i_commit_ready(i_commit_ready), .o_inst_ready(o_inst_ready),
    .o_wb_addr(wb_addr), .o_wb_data(wb_data), .o_wb_we(wb_we),
    .o_commit_valid(o_commit_valid), .o_commit_pc(o_commit_pc),
    .o_commit_next_pc(o_commit_next_pc), .o_commit_rd(o_commit_rd),
    .o_commit_wdata(o_commit_wdata), .o_commit_we(o_commit_we),
    .o_commit_halt(o_commit_halt), .o_commit_illegal(o_commit_illegal)
  );

endmodule

// ==== source/rv_execute.sv ====
// Execute unit holds one commit record and accepts a new instruction only when it drains
`timescale 1ns/1ns
`include "rv_exec_macros.svh"

module rv_execute (
  input  logic                     i_clk,
  input  logic                     i_reset,
  input  logic                     i_inst_valid,
  input  logic [`RV_XLEN-1:0]      i_pc,
  input  logic [`RV_XLEN-1:0]      i_rs1_data,
  input  logic [`RV_XLEN-1:0]      i_rs2_data,
  input  logic [`RV_XLEN-1:0]      i_imm,
  input  rv_exec_pkg::alu_op_e     i_alu_op,
  input  rv_exec_pkg::src_b_e      i_src_b,
  input  logic                     i_src_a_pc,
  input  logic                     i_word_cut,
  input  rv_exec_pkg::branch_e     i_branch,
  input  logic [`RV_NREG_BITS-1:0] i_rd,
  input  logic                     i_we,
  input  logic                     i_halt,
  input  logic                     i_illegal,
  input  logic                     i_commit_ready,
  output logic                     o_inst_ready,
  output logic [`RV_NREG_BITS-1:0] o_wb_addr,
  output logic [`RV_XLEN-1:0]      o_wb_data,
  output logic                     o_wb_we,
  output logic                     o_commit_valid,
  output logic [`RV_XLEN-1:0]      o_commit_pc,
  output logic [`RV_XLEN-1:0]      o_commit_next_pc,
  output logic [`RV_NREG_BITS-1:0] o_commit_rd,
  output logic [`RV_XLEN-1:0]      o_commit_wdata,
  output logic                     o_commit_we,
  output logic                     o_commit_halt,
  output logic                     o_commit_illegal
);
  import rv_exec_pkg::*;

  localparam int hi_bits = `RV_XLEN - `RV_WORD_BITS;

  logic [`RV_XLEN-1:0] src1, src2, imm_cut, src_a, src_b;
  logic [`RV_XLEN-1:0] add_result, sub_result, alu_raw, alu_result;
  logic [`RV_XLEN-1:0] next_pc_sum, next_pc;
  logic signed [`RV_XLEN-1:0] rem_a, rem_b, rem_result;
  logic [`RV_SHAMT_BITS-1:0] shamt;
  logic zero, less, pc_imm, accept;

  // word forms zero-extend the low halves
  assign src1    = i_word_cut ? {{hi_bits{1'b0}}, i_rs1_data[`RV_WORD_BITS-1:0]} : i_rs1_data;
  assign src2    = i_word_cut ? {{hi_bits{1'b0}}, i_rs2_data[`RV_WORD_BITS-1:0]} : i_rs2_data;
  assign imm_cut = i_word_cut ? {{hi_bits{1'b0}}, i_imm[`RV_WORD_BITS-1:0]} : i_imm;

  assign src_a = i_src_a_pc ? i_pc : src1;
  always_comb begin
    case (i_src_b)
      srcb_rs2: src_b = src2;
      srcb_imm: src_b = imm_cut;
      default:  src_b = `RV_XLEN'd4;
    endcase
  end

  assign add_result = src_a + src_b;
  assign sub_result = src_a - src_b;
  assign shamt = i_word_cut ? {1'b0, src_b[`RV_SHAMTW_BITS-1:0]} : src_b[`RV_SHAMT_BITS-1:0];

  // remw is signed on 32 bits, so rem sees sign-extended halves
  assign rem_a = i_word_cut ? {{hi_bits{src_a[`RV_WORD_BITS-1]}}, src_a[`RV_WORD_BITS-1:0]} : src_a;
  assign rem_b = i_word_cut ? {{hi_bits{src_b[`RV_WORD_BITS-1]}}, src_b[`RV_WORD_BITS-1:0]} : src_b;
  assign rem_result = (rem_b == '0) ? rem_a : rem_a % rem_b;

  always_comb begin
    case (i_alu_op)
      alu_sub:      alu_raw = sub_result;
      alu_sltu:     alu_raw = {{(`RV_XLEN-1){1'b0}}, src_a < src_b};
      alu_or:       alu_raw = src_a | src_b;
      alu_sll:      alu_raw = src_a << shamt;
      alu_rem:      alu_raw = rem_result;
      alu_copy_imm: alu_raw = i_imm;
      default:      alu_raw = add_result;
    endcase
  end

  assign alu_result = i_word_cut ?
      {{hi_bits{alu_raw[`RV_WORD_BITS-1]}}, alu_raw[`RV_WORD_BITS-1:0]} : alu_raw;

  // branch flags from the subtraction
  assign zero = (sub_result == '0);
  assign less = sub_result[`RV_XLEN-1];

  always_comb begin
    case (i_branch)
      br_jal, br_jalr: pc_imm = 1'b1;
      br_beq:          pc_imm = zero;
      br_bne:          pc_imm = !zero;
      br_blt:          pc_imm = less;
      br_bge:          pc_imm = !less;
      default:         pc_imm = 1'b0;
    endcase
  end

  assign next_pc_sum = ((i_branch == br_jalr) ? i_rs1_data : i_pc) +
                       (pc_imm ? i_imm : `RV_XLEN'd4);
  assign next_pc = (i_branch == br_jalr) ? {next_pc_sum[`RV_XLEN-1:1], 1'b0} : next_pc_sum;

  assign o_inst_ready = !o_commit_valid || i_commit_ready;
  assign accept       = i_inst_valid && o_inst_ready;

  assign o_wb_addr = i_rd;
  assign o_wb_data = alu_result;
  assign o_wb_we   = accept && i_we;

  always_ff @(posedge i_clk) begin
    if (i_reset) begin
      o_commit_valid <= 1'b0;
    end else if (accept) begin
      o_commit_valid <= 1'b1;
    end else if (i_commit_ready) begin
      o_commit_valid <= 1'b0;
    end
  end

  always_ff @(posedge i_clk) begin
    if (accept) begin
      o_commit_pc      <= i_pc;
      o_commit_next_pc <= next_pc;
      o_commit_rd      <= i_rd;
      o_commit_wdata   <= alu_result;
      o_commit_we      <= i_we;
      o_commit_halt    <= i_halt;
      o_commit_illegal <= i_illegal;
    end
  end

  commit_hold: assert property (@(posedge i_clk) disable iff (i_reset)
      o_commit_valid && !i_commit_ready |=> o_commit_valid &&
      $stable({o_commit_pc, o_commit_next_pc, o_commit_rd, o_commit_wdata,
               o_commit_we, o_commit_halt, o_commit_illegal}))
    else $error("commit record changed while stalled");

  wb_on_accept: assert property (@(posedge i_clk) disable iff (i_reset)
      o_wb_we |-> i_inst_valid && o_inst_ready && !i_halt && !i_illegal)
    else $error("register write without an accepted instruction");

endmodule

// ==== source/rv_regfile.sv ====
// Register file resets all 32 entries and ignores writes to x0
`timescale 1ns/1ns
`include "rv_exec_macros.svh"

module rv_regfile (
  input  logic                     i_clk,
  input  logic                     i_reset,
  input  logic [`RV_NREG_BITS-1:0] i_raddr1,
  input  logic [`RV_NREG_BITS-1:0] i_raddr2,
  input  logic [`RV_NREG_BITS-1:0] i_waddr,
  input  logic [`RV_XLEN-1:0]      i_wdata,
  input  logic                     i_we,
  output logic [`RV_XLEN-1:0]      o_rdata1,
  output logic [`RV_XLEN-1:0]      o_rdata2
);

  logic [`RV_XLEN-1:0] regs [`RV_NREG];

  always_ff @(posedge i_clk) begin
    if (i_reset) begin
      for (int i = 0; i < `RV_NREG; i++) begin
        regs[i] <= '0;
      end
    end else if (i_we && i_waddr != '0) begin
      regs[i_waddr] <= i_wdata;
    end
  end

  // combinational reads, a write shows up after the edge
  assign o_rdata1 = regs[i_raddr1];
  assign o_rdata2 = regs[i_raddr2];

  x0_zero: assert property (@(posedge i_clk) disable iff (i_reset) regs[0] == '0)
    else $error("x0 holds a nonzero value");

endmodule

// ==== test/tb_rv_exec.sv ====
// Reads test/tb_rv_exec_input.txt relative to the project root and expects commits in order
`timescale 1ns/1ns
`include "rv_exec_macros.svh"

module tb_rv_exec;

  localparam int max_lines  = 64;
  localparam int wait_limit = 200;

  logic                     i_clk = 1'b0;
  logic                     i_reset;
  logic                     i_inst_valid;
  logic [`RV_INST_BITS-1:0] i_inst;
  logic [`RV_XLEN-1:0]      i_pc;
  logic                     i_commit_ready = 1'b0;
  logic                     o_inst_ready;
  logic                     o_commit_valid;
  logic [`RV_XLEN-1:0]      o_commit_pc;
  logic [`RV_XLEN-1:0]      o_commit_next_pc;
  logic [`RV_NREG_BITS-1:0] o_commit_rd;
  logic [`RV_XLEN-1:0]      o_commit_wdata;
  logic                     o_commit_we;
  logic                     o_commit_halt;
  logic                     o_commit_illegal;

  // one entry per data line
  logic [`RV_INST_BITS-1:0] inst_mem [max_lines];
  logic [`RV_XLEN-1:0]      pc_mem [max_lines];
  logic [`RV_XLEN-1:0]      rd_mem [max_lines];
  logic [`RV_XLEN-1:0]      we_mem [max_lines];
  logic [`RV_XLEN-1:0]      wdata_mem [max_lines];
  logic [`RV_XLEN-1:0]      npc_mem [max_lines];
  logic [`RV_XLEN-1:0]      halt_mem [max_lines];
  logic [`RV_XLEN-1:0]      ill_mem [max_lines];

  int n_lines = 0;
  int drive_idx = 0;
  int commit_idx;
  int commit_count = 0;
  int mismatch_count = 0;
  int protocol_count = 0;
  int timeout_count = 0;
  int load_errors = 0;
  int seed = 72;
  int expect_q [$];

  rv_exec_top DUT (
    .i_clk(i_clk), .i_reset(i_reset), .i_inst_valid(i_inst_valid), .i_inst(i_inst),
    .i_pc(i_pc), .o_inst_ready(o_inst_ready), .o_commit_valid(o_commit_valid),
    .o_commit_pc(o_commit_pc), .o_commit_next_pc(o_commit_next_pc),
    .o_commit_rd(o_commit_rd), .o_commit_wdata(o_commit_wdata), .o_commit_we(o_commit_we),
    .o_commit_halt(o_commit_halt), .o_commit_illegal(o_commit_illegal),
    .i_commit_ready(i_commit_ready)
  );

  always #2 i_clk = ~i_clk;

  // random back-pressure on the commit channel
  always @(posedge i_clk) begin
    i_commit_ready <= 1'($random(seed));
  end

  task automatic compare_value(input string what, input int k,
                               input logic [`RV_XLEN-1:0] got,
                               input logic [`RV_XLEN-1:0] exp);
    if (got !== exp) begin
      mismatch_count++;
      $display("ERR %0t: entry %0d %s is %h, expected %h", $time, k, what, got, exp);
    end
  endtask

  task automatic check_commit(input int k);
    compare_value("pc", k, o_commit_pc, pc_mem[k]);
    compare_value("next pc", k, o_commit_next_pc, npc_mem[k]);
    compare_value("we", k, `RV_XLEN'(o_commit_we), we_mem[k]);
    compare_value("halt", k, `RV_XLEN'(o_commit_halt), halt_mem[k]);
    compare_value("illegal", k, `RV_XLEN'(o_commit_illegal), ill_mem[k]);
    // rd and wdata only matter when a register is written
    if (we_mem[k] != '0) begin
      compare_value("rd", k, `RV_XLEN'(o_commit_rd), rd_mem[k]);
      compare_value("wdata", k, o_commit_wdata, wdata_mem[k]);
    end
  endtask

  // both handshakes settle before the falling edge and transfer at the next rising one
  always @(negedge i_clk) begin
    if (!i_reset) begin
      if (o_commit_valid && i_commit_ready) begin
        if (expect_q.size() == 0) begin
          protocol_count++;
          $display("Protocol error at %0t: commit with no instruction outstanding", $time);
        end else begin
          commit_idx = expect_q.pop_front();
          check_commit(commit_idx);
          commit_count++;
        end
      end
      if (i_inst_valid && o_inst_ready) begin
        expect_q.push_back(drive_idx);
      end
    end
  end

  initial begin
    int fd;
    int status;
    int wait_cycles;
    string line;
    logic [`RV_INST_BITS-1:0] f_inst;
    logic [`RV_XLEN-1:0] f_pc, f_rd, f_we, f_wdata, f_npc, f_halt, f_ill;
    i_reset      <= 1'b1;
    i_inst_valid <= 1'b0;
    i_inst       <= '0;
    i_pc         <= '0;

    fd = $fopen("test/tb_rv_exec_input.txt", "r");
    if (fd == 0) begin
      load_errors++;
      $display("Could not open test/tb_rv_exec_input.txt");
    end else begin
      while (!$feof(fd) && n_lines < max_lines) begin
        status = $fgets(line, fd);
        // skip comments and blank lines
        if (status > 1 && line.getc(0) != "#") begin
          status = $sscanf(line, "%h %h %h %h %h %h %h %h",
                           f_inst, f_pc, f_rd, f_we, f_wdata, f_npc, f_halt, f_ill);
          if (status == 8) begin
            inst_mem[n_lines]  = f_inst;
            pc_mem[n_lines]    = f_pc;
            rd_mem[n_lines]    = f_rd;
            we_mem[n_lines]    = f_we;
            wdata_mem[n_lines] = f_wdata;
            npc_mem[n_lines]   = f_npc;
            halt_mem[n_lines]  = f_halt;
            ill_mem[n_lines]   = f_ill;
            n_lines++;
          end else begin
            load_errors++;
            $display("Malformed line in the input file: %s", line);
          end
        end
      end
      $fclose(fd);
    end

    repeat (3) @(posedge i_clk);
    i_reset <= 1'b0;

    for (drive_idx = 0; drive_idx < n_lines && timeout_count == 0; drive_idx++) begin
      i_inst_valid <= 1'b1;
      i_inst       <= inst_mem[drive_idx];
      i_pc         <= pc_mem[drive_idx];
      wait_cycles = 0;
      do begin
        @(negedge i_clk);
        wait_cycles++;
      end while (!o_inst_ready && wait_cycles < wait_limit);
      if (!o_inst_ready) begin
        timeout_count++;
        $display("Timeout: instruction entry %0d was never accepted", drive_idx);
      end
      @(posedge i_clk);
    end
    i_inst_valid <= 1'b0;

    // let the last commits drain
    wait_cycles = 0;
    while (expect_q.size() != 0 && wait_cycles < wait_limit) begin
      @(negedge i_clk);
      wait_cycles++;
    end
    if (expect_q.size() != 0) begin
      timeout_count++;
      $display("Timeout: %0d accepted instructions never committed", expect_q.size());
    end

    $display("Summary: %0d/%0d commits, %0d value, %0d protocol, %0d timeout, %0d file errors",
             commit_count, n_lines, mismatch_count, protocol_count, timeout_count, load_errors);
    if (n_lines > 0 && commit_count == n_lines && mismatch_count == 0 &&
        protocol_count == 0 && timeout_count == 0 && load_errors == 0) begin
      $display("Regression passed");
    end else begin
      $display("Regression failed");
    end
    $finish;
  end

endmodule

// ==== test/tb_rv_exec_input.txt ====
# columns: inst pc rd we wdata next_pc halt illegal, all in hex
# rd and wdata are compared only on lines with we set
00500093 1000 01 1 0000000000000005 1004 0 0
ffd00113 1004 02 1 fffffffffffffffd 1008 0 0
002081b3 1008 03 1 0000000000000002 100c 0 0
40208233 100c 04 1 0000000000000008 1010 0 0
0020b2b3 1010 05 1 0000000000000001 1014 0 0
0040e333 1014 06 1 000000000000000d 1018 0 0
004093b3 1018 07 1 0000000000000500 101c 0 0
02116433 101c 08 1 fffffffffffffffd 1020 0 0
0200e4b3 1020 09 1 0000000000000005 1024 0 0
80000537 1024 0a 1 ffffffff80000000 1028 0 0
fff5059b 1028 0b 1 000000007fffffff 102c 0 0
0015861b 102c 0c 1 ffffffff80000000 1030 0 0
404086bb 1030 0d 1 fffffffffffffffd 1034 0 0
12345717 1034 0e 1 0000000012346034 1038 0 0
010007ef 1038 0f 1 000000000000103c 1048 0 0
00878867 1048 10 1 000000000000104c 1044 0 0
00708013 1044 00 1 000000000000000c 1048 0 0
001008b3 1048 11 1 0000000000000005 104c 0 0
# branches, each taken and not taken
00108663 104c 0c 0 0 1058 0 0
00208663 1058 0c 0 0 105c 0 0
00209663 105c 0c 0 0 1068 0 0
00109663 1068 0c 0 0 106c 0 0
00114663 106c 0c 0 0 1078 0 0
0020c663 1078 0c 0 0 107c 0 0
0020d663 107c 0c 0 0 1088 0 0
00115663 1088 0c 0 0 108c 0 0
# ebreak, an unsupported load, then x1 read back
00100073 108c 00 0 0 1090 1 0
00003083 1090 01 0 0 1094 0 1
00008933 1094 12 1 0000000000000005 1098 0 0
